// File: compile.f
rtl/execPkg.sv
rtl/aluResultIf.sv
rtl/aluCore.sv
rtl/shiftCore.sv
rtl/flagMerge.sv
rtl/execUnit.sv
verif/execChecker.sv
verif/execUnitTb.sv

// File: rtl/aluCore.sv
`timescale 1ns/1ps

module aluCore import execPkg::*; (
    input  aluOpE        aluOp,
    input  logic         wide,
    input  wordT         opA,
    input  wordT         opB,
    input  logic         carryIn,
    aluResultIf.source   res
);

    wordT        opAw;
    wordT        opBw;
    logic [16:0] sum;        // One extra bit for carry or borrow
    logic        addType;
    logic        subType;
    logic        signA;
    logic        signB;
    logic        signR;
    logic        carryOut;
    logic        nibbleCarry;

    // Byte mode sees only the low bytes
    assign opAw = wide ? opA : {8'h00, opA[byteMsb:0]};
    assign opBw = wide ? opB : {8'h00, opB[byteMsb:0]};

    // ----------------------------------------------------------------------
    // Raw 17-bit operation
    // ----------------------------------------------------------------------
    always_comb begin
        case (aluOp)
            aluAdd:  sum = {1'b0, opAw} + {1'b0, opBw};
            aluOr:   sum = {1'b0, opAw | opBw};
            aluAdc:  sum = {1'b0, opAw} + {1'b0, opBw} + {16'h0000, carryIn};
            aluSbb:  sum = {1'b0, opAw} - {1'b0, opBw} - {16'h0000, carryIn};
            aluAnd:  sum = {1'b0, opAw & opBw};
            aluSub:  sum = {1'b0, opAw} - {1'b0, opBw};
            aluXor:  sum = {1'b0, opAw ^ opBw};
            aluCmp:  sum = {1'b0, opAw} - {1'b0, opBw};    // Flags only
            default: sum = '0;
        endcase
    end

    assign addType = (aluOp == aluAdd) || (aluOp == aluAdc);
    assign subType = (aluOp == aluSub) || (aluOp == aluSbb) || (aluOp == aluCmp);

    // Sign bits at the selected width
    assign signA = wide ? opAw[wordMsb] : opAw[byteMsb];
    assign signB = wide ? opBw[wordMsb] : opBw[byteMsb];
    assign signR = wide ? sum[wordMsb] : sum[byteMsb];

    // Upper bits are zero in byte mode, so bit 8 holds carry or borrow
    assign carryOut = wide ? sum[wordMsb + 1] : sum[byteMsb + 1];

    // Carry into bit 4, works for borrow too
    assign nibbleCarry = opAw[nibbleCarryBit] ^ opBw[nibbleCarryBit] ^ sum[nibbleCarryBit];

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------
    assign res.value = wide ? sum[wordMsb:0] : {8'h00, sum[byteMsb:0]};

    assign res.carry = (addType || subType) ? carryOut : 1'b0;    // Logic ops clear CF

    always_comb begin
        if (addType) begin
            res.overflow = (signA == signB) && (signR != signA);
        end else if (subType) begin
            res.overflow = (signA != signB) && (signR != signA);
        end else begin
            res.overflow = 1'b0;
        end
    end

    // Logic ops report result bit 4 as AF
    assign res.auxCarry = (addType || subType) ? nibbleCarry : sum[nibbleCarryBit];

endmodule

// File: rtl/aluResultIf.sv
`timescale 1ns/1ps

interface aluResultIf import execPkg::*; ();

    wordT value;      // Already masked to the operand width
    logic carry;
    logic overflow;
    logic auxCarry;

    modport source (
        output value, carry, overflow, auxCarry
    );

    modport sink (
        input value, carry, overflow, auxCarry
    );

endinterface

// File: rtl/execPkg.sv
package execPkg;

    // ----------------------------------------------------------------------
    // Data word and bit positions
    // ----------------------------------------------------------------------
    typedef logic [15:0] wordT;

    localparam int byteMsb        = 7;     // Sign bit in byte mode
    localparam int wordMsb        = 15;    // Sign bit in word mode
    localparam int nibbleCarryBit = 4;     // AF source for logic ops

    // ----------------------------------------------------------------------
    // Command and opcode encodings
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        cmdAlu,
        cmdShift,
        cmdClc,
        cmdStc,
        cmdCmc
    } cmdKindE;

    // Same order as the reg field of the 00xxx0xx opcodes
    typedef enum logic [2:0] {
        aluAdd = 3'h0,
        aluOr  = 3'h1,
        aluAdc = 3'h2,
        aluSbb = 3'h3,
        aluAnd = 3'h4,
        aluSub = 3'h5,
        aluXor = 3'h6,
        aluCmp = 3'h7
    } aluOpE;

    typedef enum logic [2:0] {
        shRol = 3'h0,
        shRor = 3'h1,
        shRcl = 3'h2,
        shRcr = 3'h3,
        shShl = 3'h4,
        shShr = 3'h5,
        shSal = 3'h6,    // Alias of SHL
        shSar = 3'h7
    } shiftOpE;

    // Jcc condition field, bit 0 of the opcode is the inversion
    typedef enum logic [2:0] {
        condO  = 3'h0,
        condC  = 3'h1,
        condZ  = 3'h2,
        condBe = 3'h3,
        condS  = 3'h4,
        condP  = 3'h5,
        condL  = 3'h6,
        condLe = 3'h7
    } condE;

    typedef struct packed {
        logic of;
        logic sf;
        logic zf;
        logic af;
        logic pf;
        logic cf;    // Bit 0
    } statusFlagsT;

endpackage

// File: rtl/execUnit.sv
`timescale 1ns/1ps

module execUnit import execPkg::*; (
    input  logic        clk25,
    input  logic        reset,

    // Command side
    input  logic        cmdStrobe,
    input  cmdKindE     cmdKind,
    input  aluOpE       aluOp,
    input  shiftOpE     shiftOp,
    input  logic        wide,       // 0 = byte, 1 = word
    input  wordT        opA,
    input  wordT        opB,
    input  condE        condSel,
    input  logic        condInvert,

    // Result side
    output logic        resultValid,
    output wordT        result,
    output statusFlagsT flags,
    output logic        condTaken
);

    wordT shiftValue;
    logic shiftCarry;
    logic carryIn;

    aluResultIf aluRes_i ();

    aluCore aluCore_i (
        .aluOp   (aluOp),
        .wide    (wide),
        .opA     (opA),
        .opB     (opB),
        .carryIn (carryIn),
        .res     (aluRes_i.source)
    );

    shiftCore shiftCore_i (
        .shiftOp    (shiftOp),
        .wide       (wide),
        .opA        (opA),
        .carryIn    (carryIn),
        .shiftValue (shiftValue),
        .shiftCarry (shiftCarry)
    );

    flagMerge flagMerge_i (
        .clk25       (clk25),
        .reset       (reset),
        .cmdStrobe   (cmdStrobe),
        .cmdKind     (cmdKind),
        .aluOp       (aluOp),
        .wide        (wide),
        .condSel     (condSel),
        .condInvert  (condInvert),
        .alu         (aluRes_i.sink),
        .shiftValue  (shiftValue),
        .shiftCarry  (shiftCarry),
        .carryIn     (carryIn),
        .resultValid (resultValid),
        .result      (result),
        .flags       (flags),
        .condTaken   (condTaken)
    );

endmodule

// File: rtl/flagMerge.sv
`timescale 1ns/1ps

module flagMerge import execPkg::*; (
    input  logic        clk25,
    input  logic        reset,
    input  logic        cmdStrobe,
    input  cmdKindE     cmdKind,
    input  aluOpE       aluOp,
    input  logic        wide,
    input  condE        condSel,
    input  logic        condInvert,
    aluResultIf.sink    alu,
    input  wordT        shiftValue,
    input  logic        shiftCarry,
    output logic        carryIn,
    output logic        resultValid,
    output wordT        result,
    output statusFlagsT flags,
    output logic        condTaken
);

    statusFlagsT nextFlags;
    wordT        selValue;
    logic        writesResult;
    logic        zero;
    logic        sign;
    logic        parity;
    logic        cond;

    assign carryIn = flags.cf;    // Next command sees the new carry at once

    // ----------------------------------------------------------------------
    // Result select and flag update
    // ----------------------------------------------------------------------
    assign selValue = (cmdKind == cmdShift) ? shiftValue : alu.value;

    // CMP and the carry commands produce no result
    assign writesResult = ((cmdKind == cmdAlu) && (aluOp != aluCmp)) || (cmdKind == cmdShift);

    assign zero   = ~|alu.value;
    assign sign   = wide ? alu.value[wordMsb] : alu.value[byteMsb];
    assign parity = ~^alu.value[7:0];    // Even number of ones

    always_comb begin
        nextFlags = flags;
        case (cmdKind)
            cmdAlu: begin
                nextFlags.of = alu.overflow;
                nextFlags.sf = sign;
                nextFlags.zf = zero;
                nextFlags.af = alu.auxCarry;
                nextFlags.pf = parity;
                nextFlags.cf = alu.carry;
            end
            cmdShift: nextFlags.cf = shiftCarry;    // Other flags untouched
            cmdClc:   nextFlags.cf = 1'b0;
            cmdStc:   nextFlags.cf = 1'b1;
            cmdCmc:   nextFlags.cf = ~flags.cf;
            default:  nextFlags = flags;
        endcase
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            resultValid <= 1'b0;
            result      <= '0;
            flags       <= '0;
        end else begin
            resultValid <= cmdStrobe && writesResult;
            if (cmdStrobe) begin
                flags <= nextFlags;
            end
            if (cmdStrobe && writesResult) begin
                result <= selValue;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Branch conditions from the registered flags
    // ----------------------------------------------------------------------
    always_comb begin
        case (condSel)
            condO:   cond = flags.of;
            condC:   cond = flags.cf;
            condZ:   cond = flags.zf;
            condBe:  cond = flags.cf | flags.zf;
            condS:   cond = flags.sf;
            condP:   cond = flags.pf;
            condL:   cond = flags.sf ^ flags.of;
            condLe:  cond = (flags.sf ^ flags.of) | flags.zf;
            default: cond = 1'b0;
        endcase
    end

    assign condTaken = cond ^ condInvert;

endmodule

// File: rtl/shiftCore.sv
`timescale 1ns/1ps

module shiftCore import execPkg::*; (
    input  shiftOpE shiftOp,
    input  logic    wide,
    input  wordT    opA,
    input  logic    carryIn,
    output wordT    shiftValue,
    output logic    shiftCarry
);

    logic topBit;

    assign topBit = wide ? opA[wordMsb] : opA[byteMsb];

    // One position only, byte results keep a zero upper byte
    always_comb begin
        case (shiftOp)
            shRol:        shiftValue = wide ? {opA[14:0], topBit}
                                            : {8'h00, opA[6:0], topBit};
            shRor:        shiftValue = wide ? {opA[0], opA[15:1]}
                                            : {8'h00, opA[0], opA[7:1]};
            shRcl:        shiftValue = wide ? {opA[14:0], carryIn}
                                            : {8'h00, opA[6:0], carryIn};
            shRcr:        shiftValue = wide ? {carryIn, opA[15:1]}
                                            : {8'h00, carryIn, opA[7:1]};
            shShl, shSal: shiftValue = wide ? {opA[14:0], 1'b0}
                                            : {8'h00, opA[6:0], 1'b0};
            shShr:        shiftValue = wide ? {1'b0, opA[15:1]}
                                            : {8'h00, 1'b0, opA[7:1]};
            shSar:        shiftValue = wide ? {topBit, opA[15:1]}    // Sign kept
                                            : {8'h00, topBit, opA[7:1]};
            default:      shiftValue = '0;
        endcase
    end

    // Left types lose the top bit, right types lose bit 0
    always_comb begin
        case (shiftOp)
            shRol, shRcl, shShl, shSal: shiftCarry = topBit;
            default:                    shiftCarry = opA[0];
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module execUnitTb -o execUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/execUnitSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1

// File: verif/execChecker.sv
`timescale 1ns/1ps

module execChecker import execPkg::*; (
    input  logic        clk25,
    input  logic        reset,
    input  logic        cmdStrobe,
    input  cmdKindE     cmdKind,
    input  aluOpE       aluOp,
    input  shiftOpE     shiftOp,
    input  logic        wide,
    input  wordT        opA,
    input  wordT        opB,
    input  condE        condSel,
    input  logic        condInvert,
    input  logic        resultValid,
    input  wordT        result,
    input  statusFlagsT flags,
    input  logic        condTaken,
    input  int          testId,
    output int          errorCount,
    output logic        reportDone
);

    localparam int numTests = 6;

    typedef struct packed {
        logic        valid;
        wordT        value;
        statusFlagsT flags;
    } expectT;

    logic        armed     = 1'b0;
    logic        finished  = 1'b0;
    logic        expValid  = 1'b0;
    wordT        expResult = '0;
    statusFlagsT expFlags  = '0;
    int          lastTest  = 0;
    int          totalChecks;
    int          totalErrors;
    int          testChecks [0:numTests + 1];
    int          testErrors [0:numTests + 1];

    assign errorCount = totalErrors;
    assign reportDone = finished;

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic expectT refModel(input cmdKindE kind, input aluOpE aop,
                                        input shiftOpE sop, input logic w, input wordT a,
                                        input wordT b, input statusFlagsT f);
        expectT      e;
        logic [31:0] mask;
        logic [31:0] ua;
        logic [31:0] ub;
        logic [31:0] cu;
        logic [31:0] r;
        logic        msbA;
        int          n;
        n       = w ? 16 : 8;
        mask    = w ? 32'hffff : 32'h00ff;
        ua      = {16'h0000, a} & mask;
        ub      = {16'h0000, b} & mask;
        cu      = (kind == cmdShift || aop == aluAdc || aop == aluSbb) ? {31'h0, f.cf} : 32'h0;
        msbA    = ua[n - 1];
        e.valid = 1'b1;
        e.flags = f;
        r       = 32'h0;
        case (kind)
            cmdAlu: begin
                if (aop inside {aluOr, aluAnd, aluXor}) begin
                    r = (aop == aluOr) ? (ua | ub) : (aop == aluAnd) ? (ua & ub) : (ua ^ ub);
                    e.flags.of = 1'b0;
                    e.flags.cf = 1'b0;
                    e.flags.af = r[4];
                end else if (aop inside {aluAdd, aluAdc}) begin
                    r = ua + ub + cu;
                    e.flags.cf = r[n];
                    e.flags.af = ((ua & 32'hf) + (ub & 32'hf) + cu) > 32'd15;
                    e.flags.of = (msbA == ub[n - 1]) && (r[n - 1] != msbA);
                end else begin
                    r = ua - ub - cu;    // Negative difference sets bit n
                    e.flags.cf = r[n];
                    e.flags.af = (ua & 32'hf) < ((ub & 32'hf) + cu);
                    e.flags.of = (msbA != ub[n - 1]) && (r[n - 1] != msbA);
                end
                r = r & mask;
                e.flags.zf = (r == 32'h0);
                e.flags.sf = r[n - 1];
                e.flags.pf = ($countones(r[7:0]) % 2) == 0;
                e.valid    = (aop != aluCmp);
            end
            cmdShift: begin
                case (sop)
                    shRol:   r = (ua << 1) | {31'h0, msbA};
                    shRor:   r = (ua >> 1) | ({31'h0, ua[0]} << (n - 1));
                    shRcl:   r = (ua << 1) | cu;
                    shRcr:   r = (ua >> 1) | (cu << (n - 1));
                    shShr:   r = ua >> 1;
                    shSar:   r = (ua >> 1) | ({31'h0, msbA} << (n - 1));
                    default: r = ua << 1;    // SHL and SAL
                endcase
                r = r & mask;
                e.flags.cf = (sop inside {shRol, shRcl, shShl, shSal}) ? msbA : ua[0];
            end
            default: begin
                e.valid    = 1'b0;
                e.flags.cf = (kind == cmdClc) ? 1'b0 : (kind == cmdStc) ? 1'b1 : ~f.cf;
            end
        endcase
        e.value = r[15:0];
        return e;
    endfunction

    function automatic logic condRef(input condE sel, input logic inv, input statusFlagsT f);
        logic c;
        case (sel)
            condO:   c = f.of;
            condC:   c = f.cf;
            condZ:   c = f.zf;
            condBe:  c = f.cf || f.zf;    // Unsigned below or equal
            condS:   c = f.sf;
            condP:   c = f.pf;
            condL:   c = (f.sf != f.of);
            default: c = (f.sf != f.of) || f.zf;
        endcase
        return c ^ inv;
    endfunction

    function automatic string testName(input int id);
        case (id)
            1:       return "reset state";
            2:       return "random ALU";
            3:       return "carry chains";
            4:       return "shifts";
            5:       return "carry commands";
            default: return "conditions";
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        testChecks[testId]++;
        totalChecks++;
        if (actual !== expected) begin
            testErrors[testId]++;
            totalErrors++;
            $display("Mismatch at time %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // ----------------------------------------------------------------------
    // Check the last rising edge and predict the next one
    // ----------------------------------------------------------------------
    always @(negedge clk25) begin
        expectT e;
        if (armed) begin
            checkValue("resultValid", 16'(expValid), 16'(resultValid));
            checkValue("result", expResult, result);
            checkValue("flags", {10'h000, expFlags}, {10'h000, flags});
            checkValue("condTaken", 16'(condRef(condSel, condInvert, expFlags)),
                       16'(condTaken));
        end
        // What the next rising edge should produce
        if (reset) begin
            expValid  = 1'b0;
            expResult = '0;
            expFlags  = '0;
            armed     = 1'b1;
        end else if (cmdStrobe) begin
            e        = refModel(cmdKind, aluOp, shiftOp, wide, opA, opB, expFlags);
            expValid = e.valid;
            expFlags = e.flags;
            if (e.valid) begin
                expResult = e.value;
            end
        end else begin
            expValid = 1'b0;
        end
        if (testId != lastTest) begin
            if (lastTest >= 1 && lastTest <= numTests) begin
                $display("Test %0d %s: %0d checks, %0d errors", lastTest,
                         testName(lastTest), testChecks[lastTest], testErrors[lastTest]);
            end
            if (testId > numTests) begin
                $display("Summary: %0d checks, %0d errors", totalChecks, totalErrors);
                finished = 1'b1;
            end
            lastTest = testId;
        end
    end

endmodule

// File: verif/execUnitTb.sv
`timescale 1ns/1ps

module execUnitTb import execPkg::*; ();

    localparam int numCommands = 400;
    localparam int cycleLimit  = 2 * numCommands + 200;    // Every command plus one gap, and margin

    logic        clk25;
    logic        reset;
    logic        cmdStrobe;
    cmdKindE     cmdKind;
    aluOpE       aluOp;
    shiftOpE     shiftOp;
    logic        wide;
    wordT        opA;
    wordT        opB;
    condE        condSel;
    logic        condInvert;
    logic        resultValid;
    wordT        result;
    statusFlagsT flags;
    logic        condTaken;
    int          testId;
    int          errorCount;
    logic        reportDone;
    int          cycleCount = 0;
    logic [31:0] rngState;

    execUnit execUnit_i (.*);

    execChecker checker_i (.*);

    initial begin
        clk25 = 1'b0;
        forever #10 clk25 = ~clk25;
    end

    always @(posedge clk25) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value    = rngState;
    endtask

    task automatic setRandomCondition();
        logic [31:0] r;
        drawRandom(r);
        condSel    = condE'(r[2:0]);
        condInvert = r[3];
    endtask

    // One strobe for one edge, then maybe an idle cycle
    task automatic sendCommand(input cmdKindE kind, input logic [2:0] op, input logic w,
                               input logic allowGap);
        logic [31:0] r;
        drawRandom(r);
        cmdStrobe = 1'b1;
        cmdKind   = kind;
        aluOp     = aluOpE'(op);
        shiftOp   = shiftOpE'(op);
        wide      = w;
        opA       = r[15:0];
        opB       = r[31:16];
        @(posedge clk25);
        #2;
        cmdStrobe = 1'b0;
        drawRandom(r);
        if (allowGap && r[0]) begin
            @(posedge clk25);
            #2;
        end
    endtask

    task automatic nextTest(input int id);
        @(posedge clk25);
        #2;
        testId = id;
    endtask

    initial begin
        logic [31:0] r;
        rngState   = 32'h6d9927b4;
        reset      = 1'b1;
        cmdStrobe  = 1'b0;
        cmdKind    = cmdAlu;
        aluOp      = aluAdd;
        shiftOp    = shRol;
        wide       = 1'b0;
        opA        = '0;
        opB        = '0;
        condSel    = condO;
        condInvert = 1'b0;
        testId     = 0;
        repeat (5) @(posedge clk25);
        #2;
        reset  = 1'b0;
        testId = 1;    // Idle cycles only
        repeat (2) @(posedge clk25);
        nextTest(2);
        for (int i = 0; i < 160; i++) begin
            drawRandom(r);
            setRandomCondition();
            sendCommand(cmdAlu, r[2:0], r[3], 1'b1);
        end
        nextTest(3);
        // Carry chains, strictly back to back
        for (int i = 0; i < 80; i++) begin
            drawRandom(r);
            case (i % 4)
                0:       sendCommand(cmdAlu, aluAdc, r[3], 1'b0);
                1:       sendCommand(cmdAlu, aluSbb, r[3], 1'b0);
                2:       sendCommand(cmdShift, shRcl, r[3], 1'b0);
                default: sendCommand(cmdShift, shRcr, r[3], 1'b0);
            endcase
        end
        nextTest(4);
        for (int i = 0; i < 80; i++) begin
            setRandomCondition();
            sendCommand(cmdShift, 3'(i % 8), 1'((i / 8) % 2), 1'b1);
        end
        nextTest(5);
        for (int i = 0; i < 40; i++) begin
            drawRandom(r);
            setRandomCondition();
            case (i % 4)
                0:       sendCommand(cmdAlu, r[2:0], r[3], 1'b1);    // Fresh flags
                1:       sendCommand(cmdCmc, 3'h0, r[3], 1'b1);
                2:       sendCommand(r[4] ? cmdStc : cmdClc, 3'h0, r[3], 1'b1);
                default: sendCommand(cmdCmc, 3'h0, r[3], 1'b0);
            endcase
        end
        nextTest(6);
        // Sweep every condition, plain then inverted
        for (int i = 0; i < 40; i++) begin
            drawRandom(r);
            condSel    = condE'(3'(i % 8));
            condInvert = 1'((i / 8) % 2);
            sendCommand(cmdAlu, r[2:0], r[3], 1'b1);
        end
        nextTest(7);
        wait (reportDone);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
